// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int wordSize = 16;
	localparam int numRegs = 4;

	// opcodes, instruction bits 15:12
	localparam logic [3:0] bneOp = 4'd0;
	localparam logic [3:0] beqOp = 4'd1;
	localparam logic [3:0] bgzOp = 4'd2;
	localparam logic [3:0] blzOp = 4'd3;
	localparam logic [3:0] adiOp = 4'd4;
	localparam logic [3:0] oriOp = 4'd5;
	localparam logic [3:0] lhiOp = 4'd6;
	localparam logic [3:0] lwdOp = 4'd7;
	localparam logic [3:0] swdOp = 4'd8;
	localparam logic [3:0] jmpOp = 4'd9;
	localparam logic [3:0] jalOp = 4'd10;
	localparam logic [3:0] rTypeOp = 4'd15;

	// function codes for rTypeOp
	localparam logic [5:0] addFn = 6'd0;
	localparam logic [5:0] subFn = 6'd1;
	localparam logic [5:0] andFn = 6'd2;
	localparam logic [5:0] orrFn = 6'd3;
	localparam logic [5:0] notFn = 6'd4;
	localparam logic [5:0] tcpFn = 6'd5;
	localparam logic [5:0] shlFn = 6'd6;
	localparam logic [5:0] shrFn = 6'd7;
	localparam logic [5:0] jprFn = 6'd25;
	localparam logic [5:0] jrlFn = 6'd26;
	localparam logic [5:0] wwdFn = 6'd28;
	localparam logic [5:0] hltFn = 6'd29;

	typedef enum logic [2:0] {IF1, IF2, IF3, ID, EX, MEM1, MEM2, WB} microState_t;

	// first eight follow the order of the R-type function codes
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr,
		aluPassB, aluShiftHigh
	} aluOp_t;

	typedef struct packed {
		logic [3:0] op;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] func;
	} rFormat_t;

	typedef struct packed {
		logic [3:0] op;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} iFormat_t;

	typedef struct packed {
		logic [3:0] op;
		logic [11:0] target;
	} jFormat_t;

	typedef union packed {
		rFormat_t rFormat;
		iFormat_t iFormat;
		jFormat_t jFormat;
	} instruction_t;

	typedef struct packed {
		logic wwd;
		logic jump;
		logic branch;
		logic link;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic regDst;
		logic aluSrc;
		logic regWrite;
		aluOp_t aluOp;
	} controlWord_t;

endpackage

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input logic [cpuPkg::wordSize-1:0] a,
	input logic [cpuPkg::wordSize-1:0] b,
	input cpuPkg::aluOp_t op,
	output logic [cpuPkg::wordSize-1:0] result
);
	import cpuPkg::*;

	localparam int halfWord = wordSize / 2;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluNot: result = ~a;
			// two's complement of the first operand
			aluTcp: result = ~a + 1'b1;
			// logical shifts, one bit only
			aluShl: result = a << 1;
			aluShr: result = a >> 1;
			aluPassB: result = b;
			// load-high-immediate, low byte of b moved up
			aluShiftHigh: result = {b[halfWord-1:0], {halfWord{1'b0}}};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input logic clk,
	input logic reset_n,
	input logic [1:0] readAddr1,
	input logic [1:0] readAddr2,
	input logic [1:0] writeAddr,
	input logic writeEnable,
	input logic [cpuPkg::wordSize-1:0] writeData,
	output logic [cpuPkg::wordSize-1:0] readData1,
	output logic [cpuPkg::wordSize-1:0] readData2
);
	import cpuPkg::*;

	logic [wordSize-1:0] regs [numRegs];

	// reads are combinational
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input logic clk,
	input logic reset_n,
	input cpuPkg::instruction_t instr,
	input logic branchTaken,
	output cpuPkg::microState_t state,
	output cpuPkg::controlWord_t ctrl,
	output logic halted,
	output logic [15:0] numInst
);
	import cpuPkg::*;

	logic isHalt;
	logic lastState;
	microState_t nextState;

	// decode, independent of the micro-state
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		isHalt = 1'b0;
		case (instr.rFormat.op)
			bneOp, beqOp, bgzOp, blzOp: begin
				ctrl.branch = 1'b1;
				ctrl.aluSrc = 1'b1;
				// a taken branch redirects the PC like a jump
				ctrl.jump = branchTaken;
			end
			adiOp: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			oriOp: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOr;
			end
			lhiOp: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluShiftHigh;
			end
			lwdOp: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			swdOp: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			jmpOp: begin
				ctrl.jump = 1'b1;
				ctrl.aluOp = aluPassB;
			end
			jalOp: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluPassB;
			end
			rTypeOp: begin
				case (instr.rFormat.func)
					addFn, subFn, andFn, orrFn, notFn, tcpFn, shlFn, shrFn: begin
						ctrl.regDst = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = aluOp_t'(instr.rFormat.func[3:0]);
					end
					jprFn: ctrl.jump = 1'b1;
					jrlFn: begin
						ctrl.jump = 1'b1;
						ctrl.link = 1'b1;
						ctrl.memToReg = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					wwdFn: ctrl.wwd = 1'b1;
					hltFn: isHalt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// sequencing, also decides which instructions skip MEM or WB
	always_comb begin
		nextState = IF1;
		lastState = 1'b0;
		case (state)
			IF1: nextState = IF2;
			IF2: nextState = IF3;
			IF3: nextState = ID;
			ID: begin
				lastState = ctrl.wwd || isHalt;
				// halt parks the sequencer in ID
				if (isHalt)
					nextState = ID;
				else if (!ctrl.wwd)
					nextState = EX;
			end
			EX: begin
				if (ctrl.memRead || ctrl.memWrite)
					nextState = MEM1;
				else if (ctrl.regWrite)
					nextState = WB;
				else
					lastState = 1'b1;
			end
			MEM1: nextState = MEM2;
			MEM2: begin
				if (ctrl.memRead)
					nextState = WB;
				else
					lastState = 1'b1;
			end
			WB: lastState = 1'b1;
			default: nextState = IF1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IF1;
			halted <= 1'b0;
			numInst <= '0;
		end else if (!halted) begin
			state <= nextState;
			if (state == ID && isHalt)
				halted <= 1'b1;
			if (lastState)
				numInst <= numInst + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input logic clk,
	input logic reset_n,
	input cpuPkg::microState_t state,
	input cpuPkg::controlWord_t ctrl,
	output cpuPkg::instruction_t instr,
	output logic branchTaken,
	output logic readM,
	output logic writeM,
	output logic [cpuPkg::wordSize-1:0] address,
	inout wire [cpuPkg::wordSize-1:0] data,
	output logic [cpuPkg::wordSize-1:0] outputPort
);
	import cpuPkg::*;

	logic [wordSize-1:0] pc;
	// memory load or link value, written back in WB
	logic [wordSize-1:0] dataReg;

	logic [wordSize-1:0] readData1;
	logic [wordSize-1:0] readData2;
	logic [wordSize-1:0] writeData;
	logic [1:0] writeAddr;
	logic writeEnable;

	logic [wordSize-1:0] immExt;
	logic [wordSize-1:0] jumpTarget;
	logic [wordSize-1:0] aluA;
	logic [wordSize-1:0] aluB;
	logic [wordSize-1:0] aluResult;
	aluOp_t aluOp;
	logic pcStep;
	logic memPhase;

	// IF2 and IF3 borrow the ALU for PC+1
	assign pcStep = (state == IF2) || (state == IF3);
	assign memPhase = (state == MEM1) || (state == MEM2);

	assign immExt = {{(wordSize - 8){instr.iFormat.imm[7]}}, instr.iFormat.imm};

	// JPR and JRL jump to rs, JMP and JAL stay in the current 4K page
	assign jumpTarget = (instr.rFormat.op == rTypeOp) ? readData1 :
		{pc[wordSize-1:12], instr.jFormat.target};

	assign aluA = (pcStep || ctrl.branch) ? pc : readData1;
	assign aluB = pcStep ? wordSize'(1) : (ctrl.aluSrc ? immExt : readData2);
	assign aluOp = pcStep ? aluAdd : ctrl.aluOp;

	// link instructions always write register 2
	assign writeAddr = ctrl.link ? 2'd2 :
		(ctrl.regDst ? instr.rFormat.rd : instr.iFormat.rt);
	assign writeData = ctrl.memToReg ? dataReg : aluResult;
	assign writeEnable = (state == WB) && ctrl.regWrite;

	// fetch from PC, otherwise the ALU holds the effective address
	assign address = (state == IF1 || state == IF2) ? pc : aluResult;
	assign data = (memPhase && ctrl.memWrite) ? readData2 : 'z;

	always_comb begin
		case (instr.iFormat.op)
			bneOp: branchTaken = readData1 != readData2;
			beqOp: branchTaken = readData1 == readData2;
			bgzOp: branchTaken = !readData1[wordSize-1] && (readData1 != '0);
			blzOp: branchTaken = readData1[wordSize-1];
			default: branchTaken = 1'b0;
		endcase
	end

	registerFile regFile (
		.clk(clk),
		.reset_n(reset_n),
		.readAddr1(instr.rFormat.rs),
		.readAddr2(instr.rFormat.rt),
		.writeAddr(writeAddr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu mainAlu (
		.a(aluA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			instr <= '0;
			readM <= 1'b0;
			writeM <= 1'b0;
			outputPort <= '0;
		end else begin
			case (state)
				IF1: readM <= 1'b1;
				IF2: begin
					instr <= data;
					readM <= 1'b0;
				end
				IF3: pc <= aluResult;
				ID: begin
					if (ctrl.wwd)
						outputPort <= readData1;
				end
				EX: begin
					// pc already points past this instruction here
					if (ctrl.jump)
						pc <= ctrl.branch ? aluResult : jumpTarget;
				end
				MEM1: begin
					readM <= ctrl.memRead;
					writeM <= ctrl.memWrite;
				end
				MEM2: begin
					readM <= 1'b0;
					writeM <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == EX && ctrl.link)
			dataReg <= pc;
		else if (state == MEM2 && ctrl.memRead)
			dataReg <= data;
	end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
	input logic clk,
	input logic reset_n,
	output logic readM,
	output logic writeM,
	output logic [cpuPkg::wordSize-1:0] address,
	inout wire [cpuPkg::wordSize-1:0] data,
	output logic [cpuPkg::wordSize-1:0] outputPort,
	output logic halted,
	output logic [15:0] numInst
);
	import cpuPkg::*;

	microState_t state;
	controlWord_t ctrl;
	instruction_t instr;
	logic branchTaken;

	controlUnit control (
		.clk(clk),
		.reset_n(reset_n),
		.instr(instr),
		.branchTaken(branchTaken),
		.state(state),
		.ctrl(ctrl),
		.halted(halted),
		.numInst(numInst)
	);

	datapath dp (
		.clk(clk),
		.reset_n(reset_n),
		.state(state),
		.ctrl(ctrl),
		.instr(instr),
		.branchTaken(branchTaken),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.outputPort(outputPort)
	);

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen (
	input logic restart,
	output logic clk,
	output logic reset_n
);
	int lowCycles;

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		lowCycles = 0;
	end

	always #2 clk = ~clk;

	// reset_n held low for three rising edges, again after each restart pulse
	always @(posedge clk) begin
		if (restart) begin
			reset_n <= 1'b0;
			lowCycles <= 0;
		end else if (!reset_n) begin
			lowCycles <= lowCycles + 1;
			if (lowCycles == 2)
				reset_n <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: test/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	typedef struct packed {
		logic halt;
		logic wwd;
		logic [15:0] value;
	} stepResult_t;

	logic clk;
	logic reset_n;
	logic restart;
	logic readM;
	logic writeM;
	logic [15:0] address;
	wire [15:0] data;
	logic [15:0] outputPort;
	logic halted;
	logic [15:0] numInst;

	logic [15:0] mem [256];
	logic [15:0] refMem [256];
	logic [15:0] refRegs [4];
	logic [15:0] refPc;
	logic [15:0] image [$];
	logic [15:0] expWwd [$];
	logic [15:0] gotWwd [$];
	// set where the retired count lands right after a WWD
	bit wwdAt [1024];
	int expCount;
	bit monitorOn;
	logic [15:0] seenInst;
	logic [31:0] rngState;
	int checks;
	int errors;

	clockGen clockGen_i (
		.restart(restart),
		.clk(clk),
		.reset_n(reset_n)
	);

	cpu dut_i (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.outputPort(outputPort),
		.halted(halted),
		.numInst(numInst)
	);

	// memory answers in the same cycle
	assign data = readM ? mem[address[7:0]] : 'z;

	always @(posedge clk) begin
		if (writeM)
			mem[address[7:0]] <= data;
	end

	// port value captured on the edge after a WWD retires
	always @(posedge clk) begin
		if (monitorOn && numInst != seenInst && numInst < 1024 && wwdAt[numInst])
			gotWwd.push_back(outputPort);
		seenInst = numInst;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] randomByte();
		rngState = xorshift(rngState);
		return rngState[7:0];
	endfunction

	function automatic logic [15:0] rInstr(input logic [5:0] fn, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
		return {rTypeOp, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iInstr(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jInstr(input logic [3:0] op, input logic [11:0] target);
		return {op, target};
	endfunction

	// one instruction on the reference copy of PC, registers and memory
	function automatic stepResult_t isaStep();
		stepResult_t res;
		logic [15:0] word;
		logic [15:0] imm;
		logic [15:0] rsVal;
		logic [15:0] rtVal;
		logic [15:0] nextPc;
		logic [15:0] branchPc;
		logic [15:0] memAddr;
		logic [1:0] rt;
		logic [1:0] rd;
		word = refMem[refPc[7:0]];
		rt = word[9:8];
		rd = word[7:6];
		rsVal = refRegs[word[11:10]];
		rtVal = refRegs[rt];
		imm = {{8{word[7]}}, word[7:0]};
		memAddr = rsVal + imm;
		nextPc = refPc + 16'd1;
		// branch offsets count from the next instruction
		branchPc = nextPc + imm;
		res = '0;
		case (word[15:12])
			bneOp: nextPc = (rsVal != rtVal) ? branchPc : nextPc;
			beqOp: nextPc = (rsVal == rtVal) ? branchPc : nextPc;
			bgzOp: nextPc = ($signed(rsVal) > 0) ? branchPc : nextPc;
			blzOp: nextPc = ($signed(rsVal) < 0) ? branchPc : nextPc;
			adiOp: refRegs[rt] = rsVal + imm;
			oriOp: refRegs[rt] = rsVal | imm;
			lhiOp: refRegs[rt] = {word[7:0], 8'h00};
			lwdOp: refRegs[rt] = refMem[memAddr[7:0]];
			swdOp: refMem[memAddr[7:0]] = rtVal;
			jmpOp: nextPc = {nextPc[15:12], word[11:0]};
			jalOp: begin
				refRegs[2] = nextPc;
				nextPc = {nextPc[15:12], word[11:0]};
			end
			rTypeOp: begin
				case (word[5:0])
					addFn: refRegs[rd] = rsVal + rtVal;
					subFn: refRegs[rd] = rsVal - rtVal;
					andFn: refRegs[rd] = rsVal & rtVal;
					orrFn: refRegs[rd] = rsVal | rtVal;
					notFn: refRegs[rd] = ~rsVal;
					tcpFn: refRegs[rd] = 16'd0 - rsVal;
					shlFn: refRegs[rd] = rsVal << 1;
					shrFn: refRegs[rd] = rsVal >> 1;
					jprFn: nextPc = rsVal;
					jrlFn: begin
						refRegs[2] = nextPc;
						nextPc = rsVal;
					end
					wwdFn: begin
						res.wwd = 1'b1;
						res.value = rsVal;
					end
					hltFn: res.halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
		refPc = nextPc;
		return res;
	endfunction

	task automatic checkValue(input string testName, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				testName, what, expected, actual);
		end
	endtask

	task automatic loadImage();
		logic [15:0] word;
		for (int a = 0; a < 256; a++) begin
			word = (a < image.size()) ? image[a] : {~a[7:0], a[7:0]};
			mem[a] <= word;
			refMem[a] = word;
		end
	endtask

	task automatic interpretProgram();
		stepResult_t res;
		int steps;
		refPc = '0;
		for (int r = 0; r < 4; r++)
			refRegs[r] = '0;
		for (int i = 0; i < 1024; i++)
			wwdAt[i] = 1'b0;
		expWwd.delete();
		expCount = 0;
		res = '0;
		steps = 0;
		while (!res.halt && steps < 1000) begin
			res = isaStep();
			steps++;
			expCount++;
			if (res.wwd) begin
				expWwd.push_back(res.value);
				wwdAt[expCount] = 1'b1;
			end
		end
		if (!res.halt) begin
			errors++;
			$display("the reference model never reached a halt instruction");
		end
	endtask

	task automatic applyReset();
		int cycles;
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!reset_n && cycles < 20);
		if (!reset_n) begin
			errors++;
			$display("reset_n was not released within 20 cycles");
		end
	endtask

	task automatic executeProgram(input string name);
		int cycles;
		loadImage();
		interpretProgram();
		gotWwd.delete();
		applyReset();
		monitorOn = 1'b1;
		cycles = 0;
		while (!halted && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		monitorOn = 1'b0;
		if (!halted) begin
			errors++;
			$display("%s: the processor did not halt within 2000 cycles", name);
		end
		checkValue(name, "retired count", 16'(expCount), numInst);
		checkValue(name, "port write count", 16'(expWwd.size()), 16'(gotWwd.size()));
		for (int i = 0; i < expWwd.size() && i < gotWwd.size(); i++)
			checkValue(name, $sformatf("port write %0d", i), expWwd[i], gotWwd[i]);
	endtask

	// sets both operands, then the taken path skips the not-taken marker
	task automatic branchCase(input logic [3:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] marker);
		image.push_back(iInstr(adiOp, 0, 1, a));
		image.push_back(iInstr(adiOp, 0, 2, b));
		image.push_back(iInstr(op, 1, 2, 8'd2));
		image.push_back(iInstr(adiOp, 0, 3, marker | 8'h40));
		image.push_back(rInstr(wwdFn, 3, 0, 0));
		image.push_back(iInstr(adiOp, 0, 3, marker));
		image.push_back(rInstr(wwdFn, 3, 0, 0));
	endtask

	initial begin
		int cycles;
		restart = 1'b0;
		monitorOn = 1'b0;
		seenInst = '0;
		rngState = 32'd47;
		checks = 0;
		errors = 0;

		// immediates, then every R-type operation
		image.delete();
		image.push_back(iInstr(adiOp, 0, 1, randomByte()));
		image.push_back(rInstr(wwdFn, 1, 0, 0));
		image.push_back(iInstr(oriOp, 1, 2, randomByte()));
		image.push_back(rInstr(wwdFn, 2, 0, 0));
		image.push_back(iInstr(lhiOp, 0, 3, randomByte()));
		image.push_back(rInstr(wwdFn, 3, 0, 0));
		for (int fn = 0; fn < 8; fn++) begin
			image.push_back(rInstr(6'(fn), 3, 2, 1));
			image.push_back(rInstr(wwdFn, 1, 0, 0));
			image.push_back(iInstr(adiOp, 1, 3, randomByte()));
		end
		image.push_back(rInstr(hltFn, 0, 0, 0));
		executeProgram("arithmetic");

		// stores around a random base, then loads back
		image.delete();
		image.push_back(iInstr(adiOp, 0, 1, 8'h60 | (randomByte() & 8'h0f)));
		for (int k = 0; k < 4; k++) begin
			image.push_back(iInstr(lhiOp, 0, 2, randomByte()));
			image.push_back(iInstr(oriOp, 2, 2, randomByte()));
			image.push_back(iInstr(swdOp, 1, 2, 8'(3 * k - 4)));
		end
		for (int k = 0; k < 4; k++) begin
			image.push_back(iInstr(lwdOp, 1, 3, 8'(3 * k - 4)));
			image.push_back(rInstr(wwdFn, 3, 0, 0));
		end
		image.push_back(rInstr(hltFn, 0, 0, 0));
		executeProgram("memory");
		for (int a = 0; a < 256; a++)
			checkValue("memory", $sformatf("word %0d", a), refMem[a], mem[a]);

		image.delete();
		branchCase(bneOp, 8'd5, 8'd5, 8'd1);
		branchCase(bneOp, 8'd5, 8'hfd, 8'd2);
		branchCase(beqOp, 8'd7, 8'd7, 8'd3);
		branchCase(beqOp, 8'd7, 8'd0, 8'd4);
		branchCase(bgzOp, 8'd9, 8'd0, 8'd5);
		branchCase(bgzOp, 8'd0, 8'd0, 8'd6);
		branchCase(bgzOp, 8'hfc, 8'd0, 8'd7);
		branchCase(blzOp, 8'hfc, 8'd0, 8'd8);
		branchCase(blzOp, 8'd0, 8'd0, 8'd9);
		branchCase(blzOp, 8'd6, 8'd0, 8'd10);
		image.push_back(rInstr(hltFn, 0, 0, 0));
		executeProgram("branches");

		// 0 -> 3 -> 8 .. 10 -> 4 .. 6 -> 12 .. 14 -> 7
		image.delete();
		image.push_back(jInstr(jmpOp, 12'd3));
		image.push_back(iInstr(adiOp, 0, 1, 8'h11));
		image.push_back(rInstr(wwdFn, 1, 0, 0));
		image.push_back(jInstr(jalOp, 12'd8));
		image.push_back(rInstr(wwdFn, 2, 0, 0));
		image.push_back(iInstr(adiOp, 0, 3, 8'd12));
		image.push_back(rInstr(jrlFn, 3, 0, 0));
		image.push_back(rInstr(hltFn, 0, 0, 0));
		image.push_back(rInstr(wwdFn, 2, 0, 0));
		image.push_back(iInstr(adiOp, 2, 1, 8'd0));
		image.push_back(rInstr(jprFn, 1, 0, 0));
		image.push_back(rInstr(hltFn, 0, 0, 0));
		image.push_back(rInstr(wwdFn, 2, 0, 0));
		image.push_back(iInstr(adiOp, 2, 1, 8'd0));
		image.push_back(rInstr(jprFn, 1, 0, 0));
		executeProgram("jumps");

		image.delete();
		image.push_back(iInstr(adiOp, 0, 1, 8'h5a));
		image.push_back(rInstr(wwdFn, 1, 0, 0));
		image.push_back(rInstr(hltFn, 0, 0, 0));
		executeProgram("halt");
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			checkValue("halt", "halted", 16'd1, {15'd0, halted});
			checkValue("halt", "readM", 16'd0, {15'd0, readM});
			checkValue("halt", "writeM", 16'd0, {15'd0, writeM});
			checkValue("halt", "retired count", 16'(expCount), numInst);
		end

		applyReset();
		checkValue("reset", "halted", 16'd0, {15'd0, halted});
		checkValue("reset", "outputPort", 16'd0, outputPort);
		checkValue("reset", "numInst", 16'd0, numInst);
		cycles = 0;
		while (!readM && cycles < 10) begin
			@(posedge clk);
			cycles++;
		end
		if (!readM) begin
			errors++;
			$display("no instruction fetch started after reset");
		end else begin
			checkValue("reset", "first fetch address", 16'd0, address);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
rtl/cpuPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpu.sv
test/clockGen.sv
test/cpuTb.sv
